// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_vga_top
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_TEXT := TEST RESULT: PASS

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+logic
logic/vga_pkg.sv
logic/vga_sync.sv
logic/digit_sprite.sv
logic/bounce_block.sv
logic/pixel_mixer.sv
logic/vga_top.sv
testbench/tb_vga_checks.sv
testbench/tb_vga_top.sv

// ==== logic/bounce_block.sv ====
`include "vga_defines.svh"

module bounce_block import vga_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  raster_t    raster,
   input  logic       refresh_tick,
   output sprite_px_t px
);

   // one axis of motion, fwd means right or down
   typedef struct packed {
      logic                fwd;
      logic [`COORD_W-1:0] pos;
   } axis_t;

   localparam logic [`COORD_W-1:0] SIZE  = `BLOCK_SIZE;
   // highest left/top corner that keeps the square visible
   localparam logic [`COORD_W-1:0] X_MAX = `H_VISIBLE - `BLOCK_SIZE;
   localparam logic [`COORD_W-1:0] Y_MAX = `V_VISIBLE - `BLOCK_SIZE;

   axis_t bx;
   axis_t by;
   axis_t bx_next;
   axis_t by_next;
   logic  in_x;
   logic  in_y;

   // ------------------------------------------------------------
   // one step along an axis, reflecting at 0 and lim
   // ------------------------------------------------------------

   function automatic axis_t axis_step(input axis_t cur, input logic [`COORD_W-1:0] lim);
      axis_t nxt;
      nxt = cur;
      if (cur.fwd)
      begin
         // at the far edge, turn and step back
         if (cur.pos == lim)
         begin
            nxt.fwd = 1'b0;
            nxt.pos = cur.pos - 1'b1;
         end
         else
            nxt.pos = cur.pos + 1'b1;
      end
      else
      begin
         // at zero, turn and step forward
         if (cur.pos == '0)
         begin
            nxt.fwd = 1'b1;
            nxt.pos = cur.pos + 1'b1;
         end
         else
            nxt.pos = cur.pos - 1'b1;
      end
      return nxt;
   endfunction

   assign bx_next = axis_step(bx, X_MAX);
   assign by_next = axis_step(by, Y_MAX);

   // ------------------------------------------------------------
   // position registers, move once per frame
   // ------------------------------------------------------------

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         bx <= '{fwd: 1'b1, pos: `COORD_W'(`BLOCK_X0)};
         by <= '{fwd: 1'b1, pos: `COORD_W'(`BLOCK_Y0)};
      end
      else if (refresh_tick)
      begin
         bx <= bx_next;
         by <= by_next;
      end
   end

   // ------------------------------------------------------------
   // square test
   // ------------------------------------------------------------

   // corner plus size stays within 10 bits, at most 640
   assign in_x = (raster.x >= bx.pos) && (raster.x < bx.pos + SIZE);
   assign in_y = (raster.y >= by.pos) && (raster.y < by.pos + SIZE);

   assign px.on  = in_x && in_y;
   assign px.rgb = `BLOCK_RGB;

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   a_inside: assert property (@(posedge clk) disable iff (reset)
      (bx.pos <= X_MAX) && (by.pos <= Y_MAX))
      else $error("bounce_block: square left screen at %0d,%0d", bx.pos, by.pos);

endmodule

// ==== logic/digit_sprite.sv ====
`include "vga_defines.svh"

module digit_sprite import vga_pkg::*;
(
   input  raster_t    raster,
   output sprite_px_t px
);

   // window corners, inclusive
   localparam logic [`COORD_W-1:0] X_L = `DIGIT_X;
   localparam logic [`COORD_W-1:0] X_R = `DIGIT_X + `DIGIT_W - 1;
   localparam logic [`COORD_W-1:0] Y_T = `DIGIT_Y;
   localparam logic [`COORD_W-1:0] Y_B = `DIGIT_Y + `DIGIT_H - 1;

   logic                in_window;
   logic [`COORD_W-1:0] dx;
   logic [`COORD_W-1:0] dy;
   logic [3:0]          rom_addr;
   logic [4:0]          rom_col;
   logic [31:0]         rom_row;
   logic                rom_bit;

   // ------------------------------------------------------------
   // window test and rom addressing
   // ------------------------------------------------------------

   assign in_window = (raster.x >= X_L) && (raster.x <= X_R) &&
                      (raster.y >= Y_T) && (raster.y <= Y_B);

   // offsets into the window
   assign dx       = raster.x - X_L;
   assign dy       = raster.y - Y_T;
   assign rom_addr = dy[3:0];
   assign rom_col  = dx[4:0];

   // ------------------------------------------------------------
   // numeral four bitmap, 16 rows of 32
   // ------------------------------------------------------------

   always_comb
   begin
      case (rom_addr)
         4'h0:    rom_row = 32'b00000000000000011111000000000000;
         4'h1:    rom_row = 32'b00000000000000111011000000000000;
         4'h2:    rom_row = 32'b00000000000011100011000000000000;
         4'h3:    rom_row = 32'b00000000000111000011000000000000;
         4'h4:    rom_row = 32'b00000000011100000011000000000000;
         4'h5:    rom_row = 32'b00000000111000000011000000000000;
         4'h6:    rom_row = 32'b00000011100000000011000000000000;
         // crossbar, two lines thick
         4'h7:    rom_row = 32'b00000111111111111111111111000000;
         4'h8:    rom_row = 32'b00000111111111111111111111000000;
         // stem
         default: rom_row = 32'b00000000000000000011000000000000;
      endcase
   end

   // msb is the leftmost column, so the glyph shows as written above
   assign rom_bit = rom_row[5'd31 - rom_col];

   assign px.on  = in_window && rom_bit;
   assign px.rgb = `DIGIT_RGB;

endmodule

// ==== logic/pixel_mixer.sv ====
`include "vga_defines.svh"

module pixel_mixer import vga_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  raster_t    raster,
   input  sync_t      sync,
   input  sprite_px_t digit_px,
   input  sprite_px_t block_px,
   output logic [2:0] rgb,
   output logic       hsync,
   output logic       vsync,
   output logic       video_on,
   output raster_t    pos
);

   logic [2:0] rgb_c;
   logic [2:0] rgb_q;
   sync_t      sync_q;
   raster_t    pos_q;

   // ------------------------------------------------------------
   // priority, block over digit over black
   // ------------------------------------------------------------

   always_comb
   begin
      if (block_px.on)
         rgb_c = block_px.rgb;
      else if (digit_px.on)
         rgb_c = digit_px.rgb;
      else
         rgb_c = 3'b000;
      // nothing drawn in blanking
      if (!sync.video_on)
         rgb_c = 3'b000;
   end

   // ------------------------------------------------------------
   // output stage, colour kept in step with sync and position
   // ------------------------------------------------------------

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rgb_q  <= 3'b000;
         sync_q <= '{hsync: 1'b1, vsync: 1'b1, video_on: 1'b0};
         pos_q  <= '0;
      end
      else
      begin
         rgb_q  <= rgb_c;
         sync_q <= sync;
         pos_q  <= raster;
      end
   end

   assign rgb      = rgb_q;
   assign hsync    = sync_q.hsync;
   assign vsync    = sync_q.vsync;
   assign video_on = sync_q.video_on;
   assign pos      = pos_q;

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   // lit output only at a visible registered position
   a_lit_visible: assert property (@(posedge clk) disable iff (reset)
      (rgb_q != 3'b000) |-> (pos_q.x < `H_VISIBLE) && (pos_q.y < `V_VISIBLE))
      else $error("pixel_mixer: colour at %0d,%0d", pos_q.x, pos_q.y);

endmodule

// ==== logic/vga_defines.svh ====
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// ------------------------------------------------------------
// display timing, 640x480 at 60 Hz, 25 MHz pixel clock
// ------------------------------------------------------------

// horizontal, in pixels
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// vertical, in lines
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// one raster coordinate, wide enough for 0..799
`define COORD_W 10

// ------------------------------------------------------------
// sprites
// ------------------------------------------------------------

// digit window, left/top corner and size
`define DIGIT_X 300
`define DIGIT_Y 10
`define DIGIT_W 32
`define DIGIT_H 16

// bouncing square, edge length and start corner
`define BLOCK_SIZE 8
`define BLOCK_X0 100
`define BLOCK_Y0 200

// 3-bit colours as {r, g, b}
`define DIGIT_RGB 3'b101
`define BLOCK_RGB 3'b010

`endif

// ==== logic/vga_pkg.sv ====
`include "vga_defines.svh"

package vga_pkg;

   // ------------------------------------------------------------
   // raster position
   // ------------------------------------------------------------

   // current pixel, x is the column, y the line
   typedef struct packed {
      logic [`COORD_W-1:0] x;
      logic [`COORD_W-1:0] y;
   } raster_t;

   // ------------------------------------------------------------
   // raster control levels
   // ------------------------------------------------------------

   // syncs are active low
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic video_on;
   } sync_t;

   // ------------------------------------------------------------
   // one picture source's pixel
   // ------------------------------------------------------------

   // rgb only meaningful when on is set
   typedef struct packed {
      logic       on;
      logic [2:0] rgb;
   } sprite_px_t;

endpackage

// ==== logic/vga_sync.sv ====
`include "vga_defines.svh"

module vga_sync import vga_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   output raster_t raster,
   output sync_t   sync,
   output logic    refresh_tick
);

   // full line and frame lengths
   localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
   localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;

   // sync pulse windows, inclusive
   localparam int HS_START = `H_VISIBLE + `H_FRONT;
   localparam int HS_END   = HS_START + `H_SYNC - 1;
   localparam int VS_START = `V_VISIBLE + `V_FRONT;
   localparam int VS_END   = VS_START + `V_SYNC - 1;

   logic [`COORD_W-1:0] x_reg;
   logic [`COORD_W-1:0] y_reg;
   logic                x_end;
   logic                y_end;

   // ------------------------------------------------------------
   // counters
   // ------------------------------------------------------------

   // last pixel of a line, last line of a frame
   assign x_end = (x_reg == H_TOTAL - 1);
   assign y_end = (y_reg == V_TOTAL - 1);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         x_reg <= '0;
         y_reg <= '0;
      end
      else
      begin
         // x every clk, wraps at 800
         if (x_end)
            x_reg <= '0;
         else
            x_reg <= x_reg + 1'b1;

         // y only on the line wrap
         if (x_end)
         begin
            if (y_end)
               y_reg <= '0;
            else
               y_reg <= y_reg + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // derived levels
   // ------------------------------------------------------------

   assign raster.x = x_reg;
   assign raster.y = y_reg;

   // pulses active low
   assign sync.hsync    = !((x_reg >= HS_START) && (x_reg <= HS_END));
   assign sync.vsync    = !((y_reg >= VS_START) && (y_reg <= VS_END));
   assign sync.video_on = (x_reg < `H_VISIBLE) && (y_reg < `V_VISIBLE);

   // one pulse per frame, at x 799 y 524
   assign refresh_tick = x_end && y_end;

   // ------------------------------------------------------------
   // checks
   // ------------------------------------------------------------

   a_x_range: assert property (@(posedge clk) disable iff (reset)
      x_reg < H_TOTAL)
      else $error("vga_sync: x reached %0d", x_reg);

   a_y_range: assert property (@(posedge clk) disable iff (reset)
      y_reg < V_TOTAL)
      else $error("vga_sync: y reached %0d", y_reg);

   // the frame pulse is a single cycle
   a_tick_single: assert property (@(posedge clk) disable iff (reset)
      refresh_tick |=> !refresh_tick)
      else $error("vga_sync: refresh tick high two cycles in a row");

endmodule

// ==== logic/vga_top.sv ====
module vga_top import vga_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   output logic [2:0] rgb,
   output logic       hsync,
   output logic       vsync,
   output logic       video_on,
   output raster_t    pos
);

   // raster and control from the sync generator
   raster_t    raster;
   sync_t      sync;
   logic       refresh_tick;

   // one pixel per picture source
   sprite_px_t digit_px;
   sprite_px_t block_px;

   // ------------------------------------------------------------
   // raster timing
   // ------------------------------------------------------------

   vga_sync i_vga_sync (
      .clk          (clk),
      .reset        (reset),
      .raster       (raster),
      .sync         (sync),
      .refresh_tick (refresh_tick)
   );

   // ------------------------------------------------------------
   // picture sources, both on the same raster position
   // ------------------------------------------------------------

   digit_sprite i_digit_sprite (
      .raster (raster),
      .px     (digit_px)
   );

   bounce_block i_bounce_block (
      .clk          (clk),
      .reset        (reset),
      .raster       (raster),
      .refresh_tick (refresh_tick),
      .px           (block_px)
   );

   // ------------------------------------------------------------
   // mix and register outputs
   // ------------------------------------------------------------

   pixel_mixer i_pixel_mixer (
      .clk      (clk),
      .reset    (reset),
      .raster   (raster),
      .sync     (sync),
      .digit_px (digit_px),
      .block_px (block_px),
      .rgb      (rgb),
      .hsync    (hsync),
      .vsync    (vsync),
      .video_on (video_on),
      .pos      (pos)
   );

endmodule

// ==== testbench/tb_vga_checks.sv ====
`include "vga_defines.svh"

module tb_vga_checks import vga_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic                ref_valid,
   input  logic [`COORD_W-1:0] ref_x,
   input  logic [`COORD_W-1:0] ref_y,
   input  logic [2:0]          rgb,
   input  logic                hsync,
   input  logic                vsync,
   input  logic                video_on,
   input  raster_t             pos,
   output logic                check_failed
);

   localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
   localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
   // sync pulse windows, inclusive
   localparam int HS_FIRST = `H_VISIBLE + `H_FRONT;
   localparam int HS_LAST  = HS_FIRST + `H_SYNC - 1;
   localparam int VS_FIRST = `V_VISIBLE + `V_FRONT;
   localparam int VS_LAST  = VS_FIRST + `V_SYNC - 1;
   // largest corner with the square still on screen
   localparam int X_HI = `H_VISIBLE - `BLOCK_SIZE;
   localparam int Y_HI = `V_VISIBLE - `BLOCK_SIZE;

   int          error_count = 0;
   int          cx;
   int          cy;
   int          blk_x;
   int          blk_y;
   int          dir_x;
   int          dir_y;
   logic        exp_visible;
   logic        exp_hsync;
   logic        exp_vsync;
   logic        in_digit;
   logic        in_block;
   logic [31:0] glyph_word;
   logic        glyph_bit;

   assign check_failed = (error_count != 0);

   task automatic flag_error(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      error_count = error_count + 1;
   endtask

   // numeral four, msb is the leftmost column
   function automatic logic [31:0] glyph_row(input int row);
      case (row)
         0:       return 32'h0001_F000;
         1:       return 32'h0003_B000;
         2:       return 32'h000E_3000;
         3:       return 32'h001C_3000;
         4:       return 32'h0070_3000;
         5:       return 32'h00E0_3000;
         6:       return 32'h0380_3000;
         7, 8:    return 32'h07FF_FFC0;
         default: return 32'h0000_3000;
      endcase
   endfunction

   // ------------------------------------------------------------
   // expected block, one diagonal step per frame
   // ------------------------------------------------------------

   // reverse when the step would leave the visible area
   function automatic int bounce_dir(input int p, input int dir, input int hi);
      if ((p + dir < 0) || (p + dir > hi))
         return -dir;
      return dir;
   endfunction

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         blk_x <= `BLOCK_X0;
         blk_y <= `BLOCK_Y0;
         dir_x <= 1;
         dir_y <= 1;
      end
      else if (ref_valid && (ref_x == H_TOTAL - 1) && (ref_y == V_TOTAL - 1))
      begin
         dir_x <= bounce_dir(blk_x, dir_x, X_HI);
         dir_y <= bounce_dir(blk_y, dir_y, Y_HI);
         blk_x <= blk_x + bounce_dir(blk_x, dir_x, X_HI);
         blk_y <= blk_y + bounce_dir(blk_y, dir_y, Y_HI);
      end
   end

   // ------------------------------------------------------------
   // expected levels at the reference position
   // ------------------------------------------------------------

   always_comb
   begin
      cx          = int'(ref_x);
      cy          = int'(ref_y);
      exp_visible = (cx < `H_VISIBLE) && (cy < `V_VISIBLE);
      exp_hsync   = !((cx >= HS_FIRST) && (cx <= HS_LAST));
      exp_vsync   = !((cy >= VS_FIRST) && (cy <= VS_LAST));
      in_digit    = (cx >= `DIGIT_X) && (cx < `DIGIT_X + `DIGIT_W) &&
                    (cy >= `DIGIT_Y) && (cy < `DIGIT_Y + `DIGIT_H);
      in_block    = (cx >= blk_x) && (cx < blk_x + `BLOCK_SIZE) &&
                    (cy >= blk_y) && (cy < blk_y + `BLOCK_SIZE);
      glyph_word  = glyph_row(cy - `DIGIT_Y);
      glyph_bit   = 1'b0;
      if (in_digit)
         glyph_bit = glyph_word[31 - (cx - `DIGIT_X)];
   end

   // ------------------------------------------------------------
   // raster order and syncs
   // ------------------------------------------------------------

   a_pos: assert property (@(posedge clk) disable iff (reset)
      ref_valid |-> (pos.x == ref_x) && (pos.y == ref_y))
      else flag_error($sformatf("pos %0d,%0d, expected %0d,%0d",
         $sampled(pos.x), $sampled(pos.y), $sampled(ref_x), $sampled(ref_y)));

   a_video_on: assert property (@(posedge clk) disable iff (reset)
      ref_valid |-> (video_on == exp_visible))
      else flag_error($sformatf("video_on wrong at %0d,%0d", $sampled(ref_x), $sampled(ref_y)));

   a_hsync: assert property (@(posedge clk) disable iff (reset)
      ref_valid |-> (hsync == exp_hsync))
      else flag_error($sformatf("hsync wrong at x %0d", $sampled(ref_x)));

   a_vsync: assert property (@(posedge clk) disable iff (reset)
      ref_valid |-> (vsync == exp_vsync))
      else flag_error($sformatf("vsync wrong at y %0d", $sampled(ref_y)));

   // ------------------------------------------------------------
   // colour
   // ------------------------------------------------------------

   a_blank: assert property (@(posedge clk) disable iff (reset)
      !video_on |-> (rgb == 3'b000))
      else flag_error($sformatf("rgb %b while blanked", $sampled(rgb)));

   a_digit: assert property (@(posedge clk) disable iff (reset)
      ref_valid && in_digit && !in_block |->
         (rgb == (glyph_bit ? `DIGIT_RGB : 3'b000)))
      else flag_error($sformatf("digit rgb %b at %0d,%0d",
         $sampled(rgb), $sampled(ref_x), $sampled(ref_y)));

   // block drawn over anything beneath it
   a_block: assert property (@(posedge clk) disable iff (reset)
      ref_valid && in_block |-> (rgb == `BLOCK_RGB))
      else flag_error($sformatf("block rgb %b at %0d,%0d, block at %0d,%0d",
         $sampled(rgb), $sampled(ref_x), $sampled(ref_y), $sampled(blk_x), $sampled(blk_y)));

   a_background: assert property (@(posedge clk) disable iff (reset)
      ref_valid && exp_visible && !in_digit && !in_block |-> (rgb == 3'b000))
      else flag_error($sformatf("background rgb %b at %0d,%0d",
         $sampled(rgb), $sampled(ref_x), $sampled(ref_y)));

endmodule

// ==== testbench/tb_vga_top.sv ====
`include "vga_defines.svh"

module tb_vga_top import vga_pkg::*;
();

   // frame geometry
   localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
   localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 8;
   localparam int FRAMES       = 3;
   // reset, three full frames, then some slack
   localparam longint RUN_LIMIT =
      longint'(RESET_CYCLES + FRAMES * H_TOTAL * V_TOTAL + 1000) * CLK_PERIOD;

   logic                clk;
   logic                reset;
   logic [2:0]          rgb;
   logic                hsync;
   logic                vsync;
   logic                video_on;
   raster_t             pos;
   logic                ref_valid;
   logic [`COORD_W-1:0] ref_x;
   logic [`COORD_W-1:0] ref_y;
   int                  frame_count;
   logic                check_failed;

   // ------------------------------------------------------------
   // clock, reset, DUT
   // ------------------------------------------------------------

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial
   begin
      clk   = 1'b0;
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

   vga_top i_vga_top (
      .clk      (clk),
      .reset    (reset),
      .rgb      (rgb),
      .hsync    (hsync),
      .vsync    (vsync),
      .video_on (video_on),
      .pos      (pos)
   );

   // ------------------------------------------------------------
   // reference raster, one clk behind the counters
   // ------------------------------------------------------------

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ref_valid   <= 1'b0;
         ref_x       <= '0;
         ref_y       <= '0;
         frame_count <= 0;
      end
      else if (!ref_valid)
         // first pixel reaches the outputs now
         ref_valid <= 1'b1;
      else if (ref_x == H_TOTAL - 1)
      begin
         ref_x <= '0;
         if (ref_y == V_TOTAL - 1)
         begin
            ref_y       <= '0;
            frame_count <= frame_count + 1;
         end
         else
            ref_y <= ref_y + 1'b1;
      end
      else
         ref_x <= ref_x + 1'b1;
   end

   tb_vga_checks i_checks (
      .clk          (clk),
      .reset        (reset),
      .ref_valid    (ref_valid),
      .ref_x        (ref_x),
      .ref_y        (ref_y),
      .rgb          (rgb),
      .hsync        (hsync),
      .vsync        (vsync),
      .video_on     (video_on),
      .pos          (pos),
      .check_failed (check_failed)
   );

   // ------------------------------------------------------------
   // end of run
   // ------------------------------------------------------------

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, why);
   endtask

   // first failed check ends the run in the same cycle
   always @(negedge clk)
   begin
      if (check_failed)
         stop_with_failure("a behavior check failed, see the line above");
   end

   always @(posedge clk)
   begin
      if (frame_count == FRAMES)
      begin
         if (check_failed)
            stop_with_failure("run ended with failed checks");
         else
         begin
            $display("TEST RESULT: PASS");
            $finish;
         end
      end
   end

   // watchdog
   initial
   begin
      #(RUN_LIMIT);
      stop_with_failure("timeout, three frames were not counted in time");
   end

endmodule
